/* Makefile */
# Verilator build and run of the rectangle fill testbench

VERILATOR ?= verilator
TOP ?= tb_fillrect
FILELIST ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

/* build.f */
+incdir+src
src/fillrect_pkg.sv
src/fill_cmd_if.sv
src/fillrect_cmd_parser.sv
src/fill_cmd_fifo.sv
src/fill_area_engine.sv
src/fillrect_top.sv
test/tb_clock_gen.sv
test/tb_fillrect.sv

/* src/fill_area_engine.sv */
// -------------------------------------
// Rectangle walker issuing byte writes
// -------------------------------------
`timescale 1ns/10ps
`include "fillrect_params.svh"

module fill_area_engine
    import fillrect_pkg::*;
(
    input logic clk,
    input logic reset,
    fill_cmd_if.reader cmd_in,
    output row_addr_t row,
    output col_addr_t col,
    output pixel_byte_t pixel,
    output logic [7:0] data_out,
    output logic ram_write_enable,
    output logic done
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_FILL,
        S_DONE
    } state_t;

    localparam pixel_byte_t LAST_PIXEL_BYTE = pixel_byte_t'(`FILLRECT_BYTES_PER_PIXEL - 1);

    state_t state;
    logic zero_area;

    color_t fill_color;
    col_addr_t col_first;
    col_addr_t col_last;
    row_addr_t row_last;

    // Next command may be taken in the done cycle
    assign cmd_in.pop = (state != S_FILL) && !cmd_in.empty;
    assign zero_area = (cmd_in.cmd.width == '0) || (cmd_in.cmd.height == '0);

    assign ram_write_enable = (state == S_FILL);
    assign done = (state == S_DONE);
    assign data_out = fill_color[pixel];

    always_ff @(posedge clk) begin
        if (cmd_in.pop) begin
            fill_color <= cmd_in.cmd.color;
            col_first <= cmd_in.cmd.x1;
            col_last <= col_addr_t'({1'b0, cmd_in.cmd.x1} + cmd_in.cmd.width - 10'd1);
            row_last <= row_addr_t'({1'b0, cmd_in.cmd.y1} + cmd_in.cmd.height - 9'd1);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            row <= '0;
            col <= '0;
            pixel <= '0;
        end else if (cmd_in.pop) begin
            row <= cmd_in.cmd.y1;
            col <= cmd_in.cmd.x1;
            pixel <= '0;
            state <= zero_area ? S_DONE : S_FILL;
        end else begin
            case (state)
                S_FILL: begin
                    // Byte index innermost, then column, then row
                    if (pixel != LAST_PIXEL_BYTE) begin
                        pixel <= pixel + 1'b1;
                    end else begin
                        pixel <= '0;
                        if (col != col_last) begin
                            col <= col + 1'b1;
                        end else begin
                            col <= col_first;
                            if (row != row_last) begin
                                row <= row + 1'b1;
                            end else begin
                                state <= S_DONE;
                            end
                        end
                    end
                end
                S_DONE: state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    // Relies on the parser clipping both extents
    a_write_on_panel: assert property (
        @(posedge clk) disable iff (reset)
        ram_write_enable |-> (col < `FILLRECT_PIXEL_WIDTH) && (row < `FILLRECT_PIXEL_HEIGHT)
    );

endmodule

/* src/fill_cmd_fifo.sv */
// -------------------------------------
// Circular queue of fill commands
// -------------------------------------
`timescale 1ns/10ps
`include "fillrect_params.svh"

module fill_cmd_fifo
    import fillrect_pkg::*;
#(
    parameter int DEPTH = `FILLRECT_CMD_DEPTH
) (
    input logic clk,
    input logic reset,
    fill_cmd_if.store wr,
    fill_cmd_if.fetch rd
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W:0] FULL_COUNT = (PTR_W + 1)'(DEPTH);

    fill_cmd_t mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0] count;

    assign wr.full = (count == FULL_COUNT);
    assign rd.empty = (count == '0);

    // Head entry is always on the read side
    assign rd.cmd = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (wr.push) begin
            mem[wr_ptr] <= wr.cmd;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr.push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd.pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({wr.push, rd.pop})
                2'b10: count <= count + 1'b1;
                2'b01: count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bounded: assert property (
        @(posedge clk) disable iff (reset) count <= FULL_COUNT
    );

    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (reset) rd.pop |-> !rd.empty
    );

endmodule

/* src/fill_cmd_if.sv */
// -------------------------------------
// Fill command link to and from queue
// -------------------------------------
`timescale 1ns/10ps
`include "fillrect_params.svh"

interface fill_cmd_if
    import fillrect_pkg::*;
();
    fill_cmd_t cmd;
    logic push;
    logic full;
    logic pop;
    logic empty;

    // Producer side of the queue
    modport writer (output cmd, output push, input full);
    modport store (input cmd, input push, output full);

    // Consumer side, cmd shows the head entry
    modport reader (output pop, input cmd, input empty);
    modport fetch (output cmd, output empty, input pop);

endinterface

/* src/fillrect_cmd_parser.sv */
// -------------------------------------
// Fill command byte parser with clipping
// -------------------------------------
`timescale 1ns/10ps
`include "fillrect_params.svh"

module fillrect_cmd_parser
    import fillrect_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic [7:0] data_in,
    input logic enable,
    output logic ready_for_data,
    fill_cmd_if.writer cmd_out
);

    typedef enum logic [2:0] {
        S_X1,
        S_Y1,
        S_WIDTH,
        S_HEIGHT,
        S_COLOR,
        S_PUSH
    } state_t;

    localparam pixel_byte_t LAST_COLOR_BYTE = pixel_byte_t'(`FILLRECT_BYTES_PER_PIXEL - 1);

    state_t state;
    logic field_byte;
    pixel_byte_t color_idx;
    logic accept;

    col_field_t x1;
    col_field_t width;
    row_addr_t y1;
    row_addr_t height;
    color_t color;
    logic [15:0] width_clip;
    logic [15:0] height_clip;

    // Extent left after start, zero when start is off the panel
    function automatic logic [15:0] clip_extent(
        input logic [15:0] start,
        input logic [15:0] len,
        input logic [15:0] limit
    );
        if (start >= limit) begin
            return '0;
        end
        if (len > limit - start) begin
            return limit - start;
        end
        return len;
    endfunction

    assign ready_for_data = (state != S_PUSH);
    assign accept = enable && ready_for_data;
    assign cmd_out.push = (state == S_PUSH) && !cmd_out.full;

    assign width_clip = clip_extent(x1.value, width.value, 16'(`FILLRECT_PIXEL_WIDTH));
    assign height_clip = clip_extent(16'(y1), 16'(height), 16'(`FILLRECT_PIXEL_HEIGHT));

    assign cmd_out.cmd = '{
        x1: col_addr_t'(x1.value),
        y1: y1,
        width: col_count_t'(width_clip),
        height: row_count_t'(height_clip),
        color: color
    };

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_X1;
            field_byte <= 1'b0;
            color_idx <= LAST_COLOR_BYTE;
        end else begin
            case (state)
                S_X1: begin
                    if (accept) begin
                        field_byte <= ~field_byte;
                        if (field_byte) begin
                            state <= S_Y1;
                        end
                    end
                end
                S_Y1: begin
                    if (accept) begin
                        state <= S_WIDTH;
                    end
                end
                S_WIDTH: begin
                    if (accept) begin
                        field_byte <= ~field_byte;
                        if (field_byte) begin
                            state <= S_HEIGHT;
                        end
                    end
                end
                S_HEIGHT: begin
                    if (accept) begin
                        state <= S_COLOR;
                    end
                end
                S_COLOR: begin
                    if (accept) begin
                        if (color_idx == '0) begin
                            state <= S_PUSH;
                        end else begin
                            color_idx <= color_idx - 1'b1;
                        end
                    end
                end
                S_PUSH: begin
                    // Held here while the queue is full
                    if (cmd_out.push) begin
                        state <= S_X1;
                        color_idx <= LAST_COLOR_BYTE;
                    end
                end
                default: state <= S_X1;
            endcase
        end
    end

    // Capture registers, little endian columns, big endian color
    always_ff @(posedge clk) begin
        if (cmd_out.push) begin
            x1 <= '0;
            width <= '0;
            y1 <= '0;
            height <= '0;
            color <= '0;
        end else if (accept) begin
            case (state)
                S_X1: x1.bytes[field_byte] <= data_in;
                S_Y1: y1 <= data_in;
                S_WIDTH: width.bytes[field_byte] <= data_in;
                S_HEIGHT: height <= data_in;
                S_COLOR: color[color_idx] <= data_in;
                default: ;
            endcase
        end
    end

    // A command waiting on a full queue is held unchanged
    a_hold_while_full: assert property (
        @(posedge clk) disable iff (reset)
        (state == S_PUSH) && !cmd_out.push |=> $stable(cmd_out.cmd)
    );

endmodule

/* src/fillrect_params.svh */
// -------------------------------------
// Panel geometry and command queue size
// -------------------------------------
`ifndef FILLRECT_PARAMS_SVH
`define FILLRECT_PARAMS_SVH

// Panel size in pixels
`define FILLRECT_PIXEL_WIDTH 320
`define FILLRECT_PIXEL_HEIGHT 240

// Bytes written per pixel
`define FILLRECT_BYTES_PER_PIXEL 2

// Default number of queued fill commands
`define FILLRECT_CMD_DEPTH 4

`endif

/* src/fillrect_pkg.sv */
// -------------------------------------
// Address types and fill command format
// -------------------------------------
`include "fillrect_params.svh"

package fillrect_pkg;

    typedef logic [8:0] col_addr_t;
    typedef logic [7:0] row_addr_t;
    typedef logic [$clog2(`FILLRECT_BYTES_PER_PIXEL)-1:0] pixel_byte_t;

    // Clipped extents, one bit wider so a full panel span fits
    typedef logic [9:0] col_count_t;
    typedef logic [8:0] row_count_t;

    // Column field as received bytes or as a number
    typedef union packed {
        logic [1:0][7:0] bytes;
        logic [15:0] value;
    } col_field_t;

    // Element 0 goes out at pixel byte 0
    typedef logic [`FILLRECT_BYTES_PER_PIXEL-1:0][7:0] color_t;

    typedef struct packed {
        col_addr_t x1;
        row_addr_t y1;
        col_count_t width;
        row_count_t height;
        color_t color;
    } fill_cmd_t;

endpackage

/* src/fillrect_top.sv */
// -------------------------------------
// Fill path: parser, queue and engine
// -------------------------------------
`timescale 1ns/10ps

module fillrect_top
    import fillrect_pkg::*;
(
    input logic clk,
    input logic reset,
    input logic [7:0] data_in,
    input logic enable,
    output logic ready_for_data,
    output row_addr_t row,
    output col_addr_t col,
    output pixel_byte_t pixel,
    output logic [7:0] data_out,
    output logic ram_write_enable,
    output logic done
);

    // Parser to queue, then queue to engine
    fill_cmd_if cmd_in ();
    fill_cmd_if cmd_out ();

    fillrect_cmd_parser i_parser (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .enable(enable),
        .ready_for_data(ready_for_data),
        .cmd_out(cmd_in.writer)
    );

    fill_cmd_fifo i_fifo (
        .clk(clk),
        .reset(reset),
        .wr(cmd_in.store),
        .rd(cmd_out.fetch)
    );

    fill_area_engine i_engine (
        .clk(clk),
        .reset(reset),
        .cmd_in(cmd_out.reader),
        .row(row),
        .col(col),
        .pixel(pixel),
        .data_out(data_out),
        .ram_write_enable(ram_write_enable),
        .done(done)
    );

endmodule

/* test/fillrect_tests.txt */
# gap x1 y1 width height color(hex), one fill command per line
# gap: idle cycles before the command, -1 for random spacing before every byte
0 10 5 3 2 f81f
3 316 20 8 2 07e0
0 100 237 2 6 001f
0 400 10 5 5 ffff
2 10 250 4 4 aaaa
5 0 0 0 4 1111
-1 260 100 60 1 1234
0 2 50 300 1 abcd
1 256 0 512 1 7e7e
4 300 200 25 45 5a5a
0 0 0 40 10 0f0f
0 20 30 2 2 0101
0 22 30 2 2 0202
0 24 30 2 2 0303
0 26 30 2 2 0404
0 28 30 2 2 0505
0 30 30 2 2 0606
-1 319 239 1 1 c3c3

/* test/tb_clock_gen.sv */
// ----------------------------------------
// Testbench clock and power-on reset
// ----------------------------------------
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int PERIOD = 40,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Released on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* test/tb_fillrect.sv */
// ----------------------------------------
// Fill path testbench: file-driven commands,
// expected write model and done tracking
// ----------------------------------------
`timescale 1ns/10ps
`include "fillrect_params.svh"

module tb_fillrect
    import fillrect_pkg::*;
();

    localparam int BPP = `FILLRECT_BYTES_PER_PIXEL;
    localparam int WAIT_LIMIT = 20000;
    localparam int RUN_LIMIT = 100000;

    logic clk;
    logic reset;
    logic [7:0] data_in;
    logic enable;
    logic ready_for_data;
    row_addr_t row;
    col_addr_t col;
    pixel_byte_t pixel;
    logic [7:0] data_out;
    logic ram_write_enable;
    logic done;

    int exp_row[$];
    int exp_col[$];
    int exp_pix[$];
    int exp_data[$];
    int exp_count[$];
    int n_cmds;
    int n_done;
    int n_writes;
    int n_checks;
    int n_errors;
    int test_errors;
    bit writing;
    bit run_over;

    tb_clock_gen i_clock (.clk(clk), .reset(reset));

    fillrect_top i_dut (
        .clk(clk),
        .reset(reset),
        .data_in(data_in),
        .enable(enable),
        .ready_for_data(ready_for_data),
        .row(row),
        .col(col),
        .pixel(pixel),
        .data_out(data_out),
        .ram_write_enable(ram_write_enable),
        .done(done)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        n_checks++;
        if (actual !== expected) begin
            n_errors++;
            $display("FAIL t=%0t %s: expected %0h, actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_timeout(input string what);
        n_errors++;
        $display("Timeout while waiting for %s at %0t", what, $time);
        run_over = 1'b1;
    endtask

    // Extent left on the panel after the start point
    function automatic int clipped(input int start, input int len, input int limit);
        if (start >= limit) begin
            return 0;
        end
        return (len < limit - start) ? len : limit - start;
    endfunction

    // Row-major writes, byte index innermost, low color byte first
    task automatic expect_fill(input int x1, input int y1, input int w, input int h,
                               input int color);
        int cw;
        int ch;
        cw = clipped(x1, w, `FILLRECT_PIXEL_WIDTH);
        ch = clipped(y1, h, `FILLRECT_PIXEL_HEIGHT);
        for (int r = y1; r < y1 + ch; r++) begin
            for (int c = x1; c < x1 + cw; c++) begin
                for (int p = 0; p < BPP; p++) begin
                    exp_row.push_back(r);
                    exp_col.push_back(c);
                    exp_pix.push_back(p);
                    exp_data.push_back((color >> (8 * p)) & 8'hff);
                end
            end
        end
        exp_count.push_back(cw * ch * BPP);
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!ready_for_data) begin
            @(negedge clk);
            cycles++;
            if (cycles > WAIT_LIMIT) begin
                report_timeout("ready_for_data");
                break;
            end
        end
    endtask

    task automatic send_byte(input logic [7:0] value, input int idle);
        repeat (idle) @(negedge clk);
        wait_ready();
        data_in = value;
        enable = 1'b1;
        @(negedge clk);
        enable = 1'b0;
    endtask

    // Little endian x1 and width, color most significant byte first
    task automatic send_command(input int gap, input logic [15:0] x1, input logic [7:0] y1,
                                input logic [15:0] w, input logic [7:0] h,
                                input logic [15:0] color);
        logic [7:0] bytes [8];
        int idle;
        bytes = '{x1[7:0], x1[15:8], y1, w[7:0], w[15:8], h, color[15:8], color[7:0]};
        for (int i = 0; i < 8; i++) begin
            if (gap < 0) begin
                idle = $urandom % 4;
            end else begin
                idle = (i == 0) ? gap : 0;
            end
            send_byte(bytes[i], idle);
        end
    endtask

    task automatic report_done();
        int expected;
        n_done++;
        writing = 1'b0;
        if (exp_count.size() == 0) begin
            n_errors++;
            $display("test %0d: done with no command outstanding", n_done);
        end else begin
            expected = exp_count.pop_front();
            if (n_writes != expected) begin
                n_errors++;
                $display("test %0d: wrong write count, %0d instead of %0d",
                         n_done, n_writes, expected);
            end else begin
                $display("test %0d: %0d writes, %0d errors", n_done, n_writes,
                         n_errors - test_errors);
            end
        end
        n_writes = 0;
        test_errors = n_errors;
    endtask

    // Outputs settle after the rising edge, so sample mid-cycle
    always @(negedge clk) begin
        if (reset === 1'b0) begin
            if (ram_write_enable === 1'b1) begin
                writing = 1'b1;
                n_writes++;
                if (exp_row.size() == 0) begin
                    n_errors++;
                    $display("Unexpected write at row %0d col %0d, t=%0t", row, col, $time);
                end else begin
                    check_value("row", 32'(row), exp_row.pop_front());
                    check_value("col", 32'(col), exp_col.pop_front());
                    check_value("pixel", 32'(pixel), exp_pix.pop_front());
                    check_value("data_out", 32'(data_out), exp_data.pop_front());
                end
            end else if (done === 1'b1) begin
                report_done();
            end else if (writing) begin
                writing = 1'b0;
                n_errors++;
                $display("Gap in the writes or late done at %0t", $time);
            end
        end
    end

    initial begin
        int fd;
        int gap;
        int x1;
        int y1;
        int w;
        int h;
        int color;
        int cycles;
        string line;
        void'($urandom(40017));
        data_in = '0;
        enable = 1'b0;
        n_cmds = 0;
        n_done = 0;
        n_writes = 0;
        n_checks = 0;
        n_errors = 0;
        test_errors = 0;
        writing = 1'b0;
        fd = $fopen("test/fillrect_tests.txt", "r");
        if (fd == 0) begin
            n_errors++;
            $display("Could not open the tests file test/fillrect_tests.txt");
            run_over = 1'b1;
        end else begin
            cycles = 0;
            while (reset !== 1'b0 && cycles <= WAIT_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (reset !== 1'b0) begin
                report_timeout("reset release");
            end
            // Quiet outputs between reset and the first byte
            repeat (3) begin
                @(negedge clk);
                check_value("ram_write_enable", 32'(ram_write_enable), 0);
                check_value("done", 32'(done), 0);
                check_value("ready_for_data", 32'(ready_for_data), 1);
            end
            while ($fgets(line, fd) != 0) begin
                if ($sscanf(line, "%d %d %d %d %d %h", gap, x1, y1, w, h, color) == 6) begin
                    expect_fill(x1, y1, w, h, color);
                    n_cmds++;
                    send_command(gap, x1[15:0], y1[7:0], w[15:0], h[7:0], color[15:0]);
                end
            end
            $fclose(fd);
            cycles = 0;
            while (n_done < n_cmds && cycles <= WAIT_LIMIT) begin
                @(negedge clk);
                cycles++;
            end
            if (n_done < n_cmds) begin
                report_timeout("done");
            end else begin
                // Settle period to catch stray writes
                repeat (10) @(negedge clk);
                run_over = 1'b1;
            end
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        while (!run_over && cycles <= RUN_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!run_over) begin
            n_errors++;
            $display("Run did not end within %0d cycles", RUN_LIMIT);
        end
        $display("%0d of %0d tests done, %0d checks, %0d errors",
                 n_done, n_cmds, n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
